// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pe_tile_left
RTL_TOP   ?= pe_tile_left
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/cgra_config_pkg.sv
package cgra_config_pkg;

	// block numbers carried in the block field of a write.
	localparam logic [15:0] BLOCK_SB  = 16'd7;
	localparam logic [15:0] BLOCK_CB0 = 16'd6;
	localparam logic [15:0] BLOCK_CB1 = 16'd5;
	localparam logic [15:0] BLOCK_CLB = 16'd4;

	// one write on the configuration port.
	typedef struct packed {
		logic        valid;
		logic [15:0] tile;
		logic [15:0] block;
		logic [31:0] data;
	} cfg_write_t;

	// connect box select, data bits 2 to 0.
	typedef logic [2:0] cb_sel_t;

	// switch box select for one output track.
	typedef logic [1:0] sb_sel_t;

	localparam sb_sel_t SB_SEL_FIRST  = 2'd0;
	localparam sb_sel_t SB_SEL_SECOND = 2'd1;
	localparam sb_sel_t SB_SEL_THIRD  = 2'd2;
	localparam sb_sel_t SB_SEL_PE     = 2'd3;

	// twelve selects, data bits 23 to 0.
	// entry index is 4 * slot + track.
	typedef sb_sel_t [11:0] sb_config_t;

	// output side slots of the switch box.
	localparam int SB_SLOT_SIDE0 = 0;
	localparam int SB_SLOT_SIDE1 = 1;
	localparam int SB_SLOT_SIDE3 = 2;

endpackage

// File: hdl/cgra_route_pkg.sv
package cgra_route_pkg;

	// tracks per side.
	localparam int TRACKS = 4;

	typedef logic [TRACKS-1:0] side_tracks_t;

	// all four sides drive into the tile.
	typedef struct packed {
		side_tracks_t side0;
		side_tracks_t side1;
		side_tracks_t side2;
		side_tracks_t side3;
	} tile_in_t;

	// side 2 is the array edge, no outputs there.
	typedef struct packed {
		side_tracks_t side0;
		side_tracks_t side1;
		side_tracks_t side3;
	} tile_out_t;

	// logic block function.
	typedef enum logic [1:0] {
		OP_AND   = 2'd0,
		OP_OR    = 2'd1,
		OP_XOR   = 2'd2,
		OP_PASS0 = 2'd3
	} clb_op_t;

endpackage

// File: hdl/clb.sv
`timescale 1ns/1ps

module clb (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    config_enable,
	input  cgra_route_pkg::clb_op_t config_data,
	input  logic                    in0,
	input  logic                    in1,
	output logic                    out
);
	import cgra_route_pkg::*;

	clb_op_t op_q;
	logic    result;

	// opcode register.
	always_ff @(posedge clk) begin
		if (rst) begin
			op_q <= OP_AND;
		end else if (config_enable) begin
			op_q <= config_data;
		end
	end

	always_comb begin
		case (op_q)
			OP_AND: begin
				result = in0 & in1;
			end
			OP_OR: begin
				result = in0 | in1;
			end
			OP_XOR: begin
				result = in0 ^ in1;
			end
			OP_PASS0: begin
				result = in0;
			end
			default: begin
				result = 1'b0;
			end
		endcase
	end

	// this flop breaks the loop
	// through the switch box and connect boxes.
	always_ff @(posedge clk) begin
		if (rst) begin
			out <= 1'b0;
		end else begin
			out <= result;
		end
	end

	// a write must carry a known opcode.
	a_op_write_known: assert property (
		@(posedge clk) disable iff (rst)
		config_enable |-> !$isunknown(config_data)
	);

endmodule

// File: hdl/connect_box.sv
`timescale 1ns/1ps

module connect_box (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     config_en,
	input  cgra_config_pkg::cb_sel_t config_data,
	input  logic [7:0]               tracks,
	output logic                     block_out
);
	import cgra_config_pkg::*;

	cb_sel_t sel_q;

	// select register, cleared to track 0.
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q <= config_data;
		end
	end

	// tracks 0 to 3 are side inputs, 4 to 7 routed outputs.
	always_comb begin
		case (sel_q)
			3'd0: begin
				block_out = tracks[0];
			end
			3'd1: begin
				block_out = tracks[1];
			end
			3'd2: begin
				block_out = tracks[2];
			end
			3'd3: begin
				block_out = tracks[3];
			end
			3'd4: begin
				block_out = tracks[4];
			end
			3'd5: begin
				block_out = tracks[5];
			end
			3'd6: begin
				block_out = tracks[6];
			end
			default: begin
				block_out = tracks[7];
			end
		endcase
	end

	// operand must be known once out of reset.
	// an X here usually means an undriven neighbour track.
	a_operand_known: assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown(block_out)
	);

endmodule

// File: hdl/pe_tile_left.sv
`timescale 1ns/1ps

module pe_tile_left (
	input  logic                        clk,
	input  logic                        rst,
	input  cgra_config_pkg::cfg_write_t cfg,
	input  logic [15:0]                 tile_id,
	input  cgra_route_pkg::tile_in_t    tile_in,
	output cgra_route_pkg::tile_out_t   tile_out
);
	import cgra_config_pkg::*;
	import cgra_route_pkg::*;

	// one strobe per configurable block.
	typedef struct packed {
		logic sb;
		logic cb0;
		logic cb1;
		logic clb;
	} block_en_t;

	block_en_t en;
	logic      tile_hit;
	logic      op_0;
	logic      op_1;
	logic      pe_out;

	assign tile_hit = cfg.valid && (cfg.tile == tile_id);

	// decode block number into a one-hot strobe.
	always_comb begin
		en = '0;
		if (tile_hit) begin
			case (cfg.block)
				BLOCK_SB: begin
					en.sb = 1'b1;
				end
				BLOCK_CB0: begin
					en.cb0 = 1'b1;
				end
				BLOCK_CB1: begin
					en.cb1 = 1'b1;
				end
				BLOCK_CLB: begin
					en.clb = 1'b1;
				end
				default: begin
					en = '0;
				end
			endcase
		end
	end

	// side inputs on tracks 0-3, routed outputs on 4-7.
	connect_box cb0 (
		.clk(clk),
		.rst(rst),
		.config_en(en.cb0),
		.config_data(cb_sel_t'(cfg.data[2:0])),
		.tracks({tile_out.side0, tile_in.side0}),
		.block_out(op_0)
	);

	connect_box cb1 (
		.clk(clk),
		.rst(rst),
		.config_en(en.cb1),
		.config_data(cb_sel_t'(cfg.data[2:0])),
		.tracks({tile_out.side1, tile_in.side1}),
		.block_out(op_1)
	);

	clb compute_block (
		.clk(clk),
		.rst(rst),
		.config_enable(en.clb),
		.config_data(clb_op_t'(cfg.data[1:0])),
		.in0(op_0),
		.in1(op_1),
		.out(pe_out)
	);

	switch_box_left sb (
		.clk(clk),
		.rst(rst),
		.config_en(en.sb),
		.config_data(sb_config_t'(cfg.data[23:0])),
		.tile_in(tile_in),
		.pe_output(pe_out),
		.tile_out(tile_out)
	);

endmodule

// File: hdl/switch_box_left.sv
`timescale 1ns/1ps

module switch_box_left (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        config_en,
	input  cgra_config_pkg::sb_config_t config_data,
	input  cgra_route_pkg::tile_in_t    tile_in,
	input  logic                        pe_output,
	output cgra_route_pkg::tile_out_t   tile_out
);
	import cgra_config_pkg::*;
	import cgra_route_pkg::*;

	sb_config_t   sel_q;
	side_tracks_t out_side0;
	side_tracks_t out_side1;
	side_tracks_t out_side3;

	// one 2-bit select per output track.
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q <= config_data;
		end
	end

	// pick among the other three sides, in side order, or the pe.
	function automatic logic pick(
		input sb_sel_t sel,
		input logic    first,
		input logic    second,
		input logic    third,
		input logic    pe
	);
		logic res;
		case (sel)
			SB_SEL_FIRST: begin
				res = first;
			end
			SB_SEL_SECOND: begin
				res = second;
			end
			SB_SEL_THIRD: begin
				res = third;
			end
			SB_SEL_PE: begin
				res = pe;
			end
			default: begin
				res = 1'b0;
			end
		endcase
		return res;
	endfunction

	always_comb begin
		for (int t = 0; t < TRACKS; t++) begin
			// side 0 draws from sides 1, 2, 3.
			out_side0[t] = pick(
				sel_q[SB_SLOT_SIDE0 * TRACKS + t],
				tile_in.side1[t],
				tile_in.side2[t],
				tile_in.side3[t],
				pe_output
			);
			// side 1 draws from sides 0, 2, 3.
			out_side1[t] = pick(
				sel_q[SB_SLOT_SIDE1 * TRACKS + t],
				tile_in.side0[t],
				tile_in.side2[t],
				tile_in.side3[t],
				pe_output
			);
			// side 3 draws from sides 0, 1, 2.
			out_side3[t] = pick(
				sel_q[SB_SLOT_SIDE3 * TRACKS + t],
				tile_in.side0[t],
				tile_in.side1[t],
				tile_in.side2[t],
				pe_output
			);
		end
	end

	assign tile_out = '{
		side0: out_side0,
		side1: out_side1,
		side3: out_side3
	};

	// a write during reset would be dropped.
	a_no_write_in_reset: assert property (
		@(posedge clk)
		!(rst && config_en)
	);

endmodule

// File: sim/tb_pe_tile_left.sv
`timescale 1ns/1ps

module tb_pe_tile_left;
	import cgra_config_pkg::*;
	import cgra_route_pkg::*;

	localparam logic [15:0] TILE_ID    = 16'h0a3c;
	localparam int          MAX_CYCLES = 2000;
	localparam int          SOAK_STEPS = 300;

	// one row of the stimulus table.
	typedef struct packed {
		logic        valid;
		logic [15:0] tile;
		logic [15:0] block;
		logic [31:0] data;
		tile_in_t    tin;
		tile_out_t   expect_out;
	} step_t;

	logic        clk;
	logic        rst;
	cfg_write_t  cfg;
	logic [15:0] tile_id;
	tile_in_t    tile_in;
	tile_out_t   tile_out;

	step_t steps[$];

	// reference state of the tile.
	logic [23:0] model_sb;
	logic [2:0]  model_cb0;
	logic [2:0]  model_cb1;
	logic [1:0]  model_op;
	logic        model_pe;

	int   errors;
	int   checks;
	logic run_done = 1'b0;

	pe_tile_left dut (
		.clk(clk),
		.rst(rst),
		.cfg(cfg),
		.tile_id(tile_id),
		.tile_in(tile_in),
		.tile_out(tile_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// select 0 to 2 walks the other three sides upward, 3 takes the pe.
	function automatic tile_out_t route_outputs(
		input tile_in_t    tin,
		input logic [23:0] sel,
		input logic        pe
	);
		side_tracks_t src[4];
		side_tracks_t res[3];
		logic         cand[3];
		logic [1:0]   s2;
		int           side;
		int           n;
		tile_out_t    result;
		src[0] = tin.side0;
		src[1] = tin.side1;
		src[2] = tin.side2;
		src[3] = tin.side3;
		for (int k = 0; k < 3; k++) begin
			side = (k == 2) ? 3 : k;
			for (int t = 0; t < 4; t++) begin
				n = 0;
				for (int j = 0; j < 4; j++) begin
					if (j != side) begin
						cand[n] = src[j][t];
						n++;
					end
				end
				s2 = sel[2 * (4 * k + t) +: 2];
				if (s2 == 2'd3) begin
					res[k][t] = pe;
				end else begin
					res[k][t] = cand[s2];
				end
			end
		end
		result.side0 = res[0];
		result.side1 = res[1];
		result.side3 = res[2];
		return result;
	endfunction

	// tracks 0 to 3 from the side inputs, 4 to 7 from that side's outputs.
	function automatic logic pick_operand(
		input logic [2:0]   sel,
		input side_tracks_t in_side,
		input side_tracks_t out_side
	);
		logic [7:0] tracks;
		tracks = {out_side, in_side};
		return tracks[sel];
	endfunction

	function automatic logic apply_opcode(
		input logic [1:0] op,
		input logic       a,
		input logic       b
	);
		logic r;
		case (op)
			2'd0: r = a & b;
			2'd1: r = a | b;
			2'd2: r = a ^ b;
			default: r = a;
		endcase
		return r;
	endfunction

	function automatic tile_in_t random_inputs();
		logic [31:0] r;
		r = $urandom;
		return tile_in_t'(r[15:0]);
	endfunction

	// appends a row and advances the model across one clock edge.
	task automatic push_step(
		input logic        valid,
		input logic [15:0] tile,
		input logic [15:0] block,
		input logic [31:0] data
	);
		step_t     s;
		tile_out_t exp_out;
		logic      op0;
		logic      op1;
		logic      pe_next;
		s.valid = valid;
		s.tile = tile;
		s.block = block;
		s.data = data;
		s.tin = random_inputs();
		exp_out = route_outputs(s.tin, model_sb, model_pe);
		s.expect_out = exp_out;
		steps.push_back(s);
		op0 = pick_operand(model_cb0, s.tin.side0, exp_out.side0);
		op1 = pick_operand(model_cb1, s.tin.side1, exp_out.side1);
		pe_next = apply_opcode(model_op, op0, op1);
		if (valid && tile == TILE_ID) begin
			case (block)
				BLOCK_SB: model_sb = data[23:0];
				BLOCK_CB0: model_cb0 = data[2:0];
				BLOCK_CB1: model_cb1 = data[2:0];
				BLOCK_CLB: model_op = data[1:0];
				default: ;
			endcase
		end
		model_pe = pe_next;
	endtask

	task automatic idle_steps(input int count);
		for (int i = 0; i < count; i++) begin
			push_step(1'b0, 16'h0000, 16'h0000, 32'h0000_0000);
		end
	endtask

	task automatic write_step(input logic [15:0] block, input logic [31:0] data);
		push_step(1'b1, TILE_ID, block, data);
	endtask

	task automatic build_table();
		logic [31:0] r;
		logic [15:0] blk;
		logic [1:0]  v;
		int          sel1;
		model_sb = '0;
		model_cb0 = '0;
		model_cb1 = '0;
		model_op = '0;
		model_pe = 1'b0;
		// reset routing.
		idle_steps(8);
		// pe on side 3 so stray compute writes show up.
		write_step(BLOCK_SB, 32'h00ff_0000);
		// foreign tiles, unknown blocks and an idle strobe.
		push_step(1'b1, TILE_ID ^ 16'h0001, BLOCK_SB, 32'h00ff_ffff);
		push_step(1'b1, TILE_ID ^ 16'h8000, BLOCK_CB0, 32'h0000_0007);
		push_step(1'b1, 16'h0000, BLOCK_CB1, 32'h0000_0007);
		push_step(1'b1, ~TILE_ID, BLOCK_CLB, 32'h0000_0003);
		push_step(1'b1, TILE_ID, 16'd0, 32'hffff_ffff);
		push_step(1'b1, TILE_ID, 16'd3, 32'hffff_ffff);
		push_step(1'b1, TILE_ID, 16'd8, 32'hffff_ffff);
		push_step(1'b1, TILE_ID, 16'hffff, 32'hffff_ffff);
		push_step(1'b0, TILE_ID, BLOCK_SB, 32'h00ff_ffff);
		idle_steps(1);
		// every select value on every output.
		for (int i = 0; i < 4; i++) begin
			v = i[1:0];
			write_step(BLOCK_SB, {8'h00, {12{v}}});
			idle_steps(3);
		end
		for (int i = 0; i < 4; i++) begin
			r = $urandom;
			write_step(BLOCK_SB, {8'h00, r[23:0]});
			idle_steps(2);
		end
		// compute path with the pe on all side 3 tracks.
		for (int c = 0; c < 8; c++) begin
			for (int op = 0; op < 4; op++) begin
				r = $urandom;
				sel1 = c * 3 + op;
				write_step(BLOCK_SB, {8'h00, 8'hff, r[15:0]});
				write_step(BLOCK_CB0, {29'h0, c[2:0]});
				write_step(BLOCK_CB1, {29'h0, sel1[2:0]});
				write_step(BLOCK_CLB, {30'h0, op[1:0]});
				idle_steps(2);
			end
		end
		// soak.
		for (int i = 0; i < SOAK_STEPS; i++) begin
			r = $urandom;
			if (r[1:0] == 2'b00) begin
				if (r[4] == 1'b0) begin
					blk = 16'd4 + {14'h0, r[3:2]};
				end else begin
					blk = r[31:16];
				end
				push_step(1'b1, r[5] ? TILE_ID : r[21:6], blk, $urandom);
			end else begin
				idle_steps(1);
			end
		end
	endtask

	task automatic check_outputs(input tile_out_t exp_out);
		checks += 3;
		assert (tile_out.side0 === exp_out.side0) else begin
			errors++;
			$display("Fail: time %0t, signal tile_out.side0, expected %h, actual %h",
				$time, exp_out.side0, tile_out.side0);
		end
		assert (tile_out.side1 === exp_out.side1) else begin
			errors++;
			$display("Fail: time %0t, signal tile_out.side1, expected %h, actual %h",
				$time, exp_out.side1, tile_out.side1);
		end
		assert (tile_out.side3 === exp_out.side3) else begin
			errors++;
			$display("Fail: time %0t, signal tile_out.side3, expected %h, actual %h",
				$time, exp_out.side3, tile_out.side3);
		end
	endtask

	task automatic apply_table();
		for (int i = 0; i < steps.size(); i++) begin
			cfg.valid = steps[i].valid;
			cfg.tile = steps[i].tile;
			cfg.block = steps[i].block;
			cfg.data = steps[i].data;
			tile_in = steps[i].tin;
			// sample mid cycle away from both edges.
			#5;
			check_outputs(steps[i].expect_out);
			@(posedge clk);
			#1;
		end
		cfg = '0;
	endtask

	initial begin
		void'($urandom(32'h2410cf6f));
		rst = 1'b1;
		cfg = '0;
		tile_id = TILE_ID;
		tile_in = '0;
		errors = 0;
		checks = 0;
		build_table();
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
		end
		#1;
		rst = 1'b0;
		apply_table();
		run_done = 1'b1;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// watchdog.
	initial begin
		int cycles;
		cycles = 0;
		while (!run_done && cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (!run_done) begin
			$display("Timeout: the table was not finished within %0d cycles", MAX_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

endmodule

// File: sources.f
hdl/cgra_config_pkg.sv
hdl/cgra_route_pkg.sv
hdl/connect_box.sv
hdl/clb.sv
hdl/switch_box_left.sv
hdl/pe_tile_left.sv
sim/tb_pe_tile_left.sv
